// ==== opl_pkg.sv ====
// FM synth shared definitions
package opl_pkg;

    localparam int NUM_CHANNELS    = 4;   // channel slots per frame
    localparam int CLK_DIV_COUNT   = 16;  // clocks per sample tick
    localparam int DIV_WIDTH       = $clog2(CLK_DIV_COUNT);
    localparam int FNUM_WIDTH      = 10;
    localparam int BLOCK_WIDTH     = 3;
    localparam int MULT_WIDTH      = 4;
    localparam int TL_WIDTH        = 4;
    localparam int PHASE_WIDTH     = 20;  // phase accumulator
    localparam int SINE_ADDR_WIDTH = 5;   // quarter-wave table address
    localparam int SINE_WIDTH      = 8;   // unsigned table entry
    localparam int PHASE_IDX_WIDTH = SINE_ADDR_WIDTH + 2; // quadrant + index
    localparam int OP_OUT_WIDTH    = 9;   // signed operator output
    localparam int SAMPLE_WIDTH    = 12;  // signed mixed sample
    localparam int SLOT_WIDTH      = 2;
    localparam int REG_WIDTH       = 8;   // register port addr/data

    // upper address nibble selects the register group
    typedef enum logic [3:0] {
        REG_MULT      = 4'h2,
        REG_TL        = 4'h4,
        REG_FNUM_LO   = 4'hA,
        REG_KEY_BLOCK = 4'hB,
        REG_OUTPUT    = 4'hC
    } reg_group_e;

    typedef enum logic {
        SLOT_IDLE,  // waiting for sample tick
        SLOT_RUN    // stepping through slots
    } slot_state_e;

    typedef struct packed {
        logic                   kon;
        logic [BLOCK_WIDTH-1:0] block;
        logic [FNUM_WIDTH-1:0]  fnum;
        logic [MULT_WIDTH-1:0]  mult;
        logic [TL_WIDTH-1:0]    tl;
        logic                   left_en;
        logic                   right_en;
    } chan_cfg_t;

    // phase generator to operator
    typedef struct packed {
        logic                       valid;
        logic                       last;        // slot 3 of the frame
        logic [PHASE_IDX_WIDTH-1:0] phase_index; // top phase bits
        logic [TL_WIDTH-1:0]        tl;
        logic                       kon;
        logic                       left_en;
        logic                       right_en;
    } op_req_t;

    // operator to mixer
    typedef struct packed {
        logic                           valid;
        logic                           last;
        logic                           left_en;
        logic                           right_en;
        logic signed [OP_OUT_WIDTH-1:0] value;
    } slot_out_t;

endpackage

// ==== opl_register_file.sv ====
// FM synth register file
`timescale 1ns/1ps

module opl_register_file
    import opl_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 wr,
    input  logic [REG_WIDTH-1:0] addr,
    input  logic [REG_WIDTH-1:0] data,
    output chan_cfg_t            chan_cfg [NUM_CHANNELS]
);

    reg_group_e            group;     // upper nibble
    logic [SLOT_WIDTH-1:0] chan;      // channel within group
    logic                  chan_ok;   // low nibble in range

    assign group   = reg_group_e'(addr[7:4]);
    assign chan    = addr[SLOT_WIDTH-1:0];
    assign chan_ok = (addr[3:SLOT_WIDTH] == '0);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < NUM_CHANNELS; i++) begin
                chan_cfg[i] <= '0;  // all keys off, silent
            end
        end else if (wr && chan_ok) begin
            case (group)
                REG_MULT: begin
                    chan_cfg[chan].mult <= data[MULT_WIDTH-1:0];
                end
                REG_TL: begin
                    chan_cfg[chan].tl <= data[TL_WIDTH-1:0];
                end
                REG_FNUM_LO: begin
                    chan_cfg[chan].fnum[7:0] <= data;  // low fnum byte
                end
                REG_KEY_BLOCK: begin
                    chan_cfg[chan].kon       <= data[5];
                    chan_cfg[chan].block     <= data[4:2];
                    chan_cfg[chan].fnum[9:8] <= data[1:0];
                end
                REG_OUTPUT: begin
                    chan_cfg[chan].left_en  <= data[4];
                    chan_cfg[chan].right_en <= data[5];
                end
                default: begin
                    // unmapped group, write dropped
                end
            endcase
        end
    end

    // host must present a clean address and data with the strobe
    a_wr_known: assert property (
        @(posedge clk) disable iff (!rst_n)
        wr |-> !$isunknown({addr, data})
    ) else $error("register write with unknown addr or data");

endmodule

// ==== opl_phase_generator.sv ====
// FM synth phase generator
`timescale 1ns/1ps

module opl_phase_generator
    import opl_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      sample_clk_en,
    input  chan_cfg_t chan_cfg [NUM_CHANNELS],
    output op_req_t   op_req
);

    slot_state_e            state;
    logic [SLOT_WIDTH-1:0]  slot;                  // current slot in frame
    logic [PHASE_WIDTH-1:0] phase [NUM_CHANNELS];  // per-channel accumulators
    chan_cfg_t              cfg;                   // current slot settings
    logic [PHASE_WIDTH-1:0] fnum_shifted;
    logic [PHASE_WIDTH-1:0] phase_inc;
    logic                   last_slot;

    assign cfg          = chan_cfg[slot];
    assign fnum_shifted = PHASE_WIDTH'(cfg.fnum) << cfg.block;
    assign phase_inc    = PHASE_WIDTH'(fnum_shifted * PHASE_WIDTH'(cfg.mult)); // wraps
    assign last_slot    = (slot == SLOT_WIDTH'(NUM_CHANNELS - 1));

    // request reflects the phase before this slot's update
    always_comb begin
        op_req.valid       = (state == SLOT_RUN);
        op_req.last        = (state == SLOT_RUN) && last_slot;
        op_req.phase_index = phase[slot][PHASE_WIDTH-1 -: PHASE_IDX_WIDTH];
        op_req.tl          = cfg.tl;
        op_req.kon         = cfg.kon;
        op_req.left_en     = cfg.left_en;
        op_req.right_en    = cfg.right_en;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= SLOT_IDLE;
            slot  <= '0;
            for (int i = 0; i < NUM_CHANNELS; i++) begin
                phase[i] <= '0;
            end
        end else begin
            case (state)
                SLOT_IDLE: begin
                    slot <= '0;
                    if (sample_clk_en) state <= SLOT_RUN;  // start of frame
                end
                SLOT_RUN: begin
                    phase[slot] <= cfg.kon ? phase[slot] + phase_inc : '0; // key off holds 0
                    slot        <= slot + 1'b1;
                    if (last_slot) state <= SLOT_IDLE;
                end
                default: state <= SLOT_IDLE;
            endcase
        end
    end

    // frame must finish before the divider fires again
    a_no_tick_in_run: assert property (
        @(posedge clk) disable iff (!rst_n)
        (state == SLOT_RUN) |-> !sample_clk_en
    ) else $error("sample tick arrived during slot processing");

endmodule

// ==== opl_operator.sv ====
// FM synth sine operator
`timescale 1ns/1ps

module opl_operator
    import opl_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  op_req_t   op_req,
    output slot_out_t slot_out
);

    // stage 1 holds the table magnitude plus what stage 2 needs
    typedef struct packed {
        logic                  valid;
        logic                  last;
        logic                  negate;   // lower half of the wave
        logic [TL_WIDTH-1:0]   tl;
        logic                  kon;
        logic                  left_en;
        logic                  right_en;
        logic [SINE_WIDTH-1:0] mag;
    } op_stage1_t;

    logic [SINE_WIDTH-1:0]          sine_rom [2**SINE_ADDR_WIDTH]; // quarter wave
    logic [1:0]                     quadrant;
    logic [SINE_ADDR_WIDTH-1:0]     rom_addr;
    op_stage1_t                     s1;
    logic signed [OP_OUT_WIDTH-1:0] signed_val;
    logic signed [OP_OUT_WIDTH-1:0] level_val;

    initial $readmemh("sine_table.mem", sine_rom);

    assign quadrant = op_req.phase_index[PHASE_IDX_WIDTH-1 -: 2];
    // odd quadrants run the table backwards, ~i is 31-i
    assign rom_addr = quadrant[0] ? ~op_req.phase_index[SINE_ADDR_WIDTH-1:0]
                                  :  op_req.phase_index[SINE_ADDR_WIDTH-1:0];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            s1 <= '0;
        end else begin
            s1.valid    <= op_req.valid;
            s1.last     <= op_req.last;
            s1.negate   <= quadrant[1];
            s1.tl       <= op_req.tl;
            s1.kon      <= op_req.kon;
            s1.left_en  <= op_req.left_en;
            s1.right_en <= op_req.right_en;
            s1.mag      <= sine_rom[rom_addr];  // registered rom read
        end
    end

    assign signed_val = s1.negate ? -$signed({1'b0, s1.mag}) : $signed({1'b0, s1.mag});
    assign level_val  = signed_val >>> s1.tl;  // tl attenuation, 6 dB per step

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            slot_out <= '0;
        end else begin
            slot_out.valid    <= s1.valid;
            slot_out.last     <= s1.last;
            slot_out.left_en  <= s1.left_en;
            slot_out.right_en <= s1.right_en;
            slot_out.value    <= s1.kon ? level_val : '0;  // keyed-off slot is silent
        end
    end

endmodule

// ==== opl_channel_mixer.sv ====
// FM synth stereo mixer
`timescale 1ns/1ps

module opl_channel_mixer
    import opl_pkg::*;
(
    input  logic                           clk,
    input  logic                           rst_n,
    input  slot_out_t                      slot_out,
    output logic signed [SAMPLE_WIDTH-1:0] sample_l,
    output logic signed [SAMPLE_WIDTH-1:0] sample_r,
    output logic                           sample_valid
);

    logic signed [SAMPLE_WIDTH-1:0] acc_l;     // running left sum
    logic signed [SAMPLE_WIDTH-1:0] acc_r;     // running right sum
    logic signed [SAMPLE_WIDTH-1:0] slot_ext;  // sign-extended slot value
    logic signed [SAMPLE_WIDTH-1:0] add_l;
    logic signed [SAMPLE_WIDTH-1:0] add_r;

    assign slot_ext = SAMPLE_WIDTH'($signed(slot_out.value));
    assign add_l    = slot_out.left_en  ? slot_ext : '0;  // routing gates
    assign add_r    = slot_out.right_en ? slot_ext : '0;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            acc_l        <= '0;
            acc_r        <= '0;
            sample_l     <= '0;
            sample_r     <= '0;
            sample_valid <= 1'b0;
        end else begin
            sample_valid <= 1'b0;  // single-cycle pulse
            if (slot_out.valid) begin
                if (slot_out.last) begin
                    sample_l     <= acc_l + add_l;  // frame complete
                    sample_r     <= acc_r + add_r;
                    acc_l        <= '0;
                    acc_r        <= '0;
                    sample_valid <= 1'b1;
                end else begin
                    acc_l <= acc_l + add_l;
                    acc_r <= acc_r + add_r;
                end
            end
        end
    end

    // one last per frame, so pulses can never touch
    a_valid_pulse: assert property (
        @(posedge clk) disable iff (!rst_n)
        sample_valid |=> !sample_valid
    ) else $error("sample_valid high on consecutive cycles");

endmodule

// ==== opl_synth.sv ====
// FM synth top level
`timescale 1ns/1ps

module opl_synth
    import opl_pkg::*;
(
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           wr,
    input  logic [REG_WIDTH-1:0]           addr,
    input  logic [REG_WIDTH-1:0]           data,
    output logic signed [SAMPLE_WIDTH-1:0] sample_l,
    output logic signed [SAMPLE_WIDTH-1:0] sample_r,
    output logic                           sample_valid
);

    logic [DIV_WIDTH-1:0] div_cnt;   // sample clock divider
    logic                 sample_clk_en;
    chan_cfg_t            chan_cfg [NUM_CHANNELS];
    op_req_t              op_req;
    slot_out_t            slot_out;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            div_cnt       <= '0;
            sample_clk_en <= 1'b0;
        end else begin
            div_cnt       <= (div_cnt == DIV_WIDTH'(CLK_DIV_COUNT - 1)) ? '0 : div_cnt + 1'b1;
            sample_clk_en <= (div_cnt == DIV_WIDTH'(CLK_DIV_COUNT - 1));  // tick on wrap
        end
    end

    opl_register_file u_register_file (
        .clk      (clk),
        .rst_n    (rst_n),
        .wr       (wr),
        .addr     (addr),
        .data     (data),
        .chan_cfg (chan_cfg)
    );

    opl_phase_generator u_phase_generator (
        .clk           (clk),
        .rst_n         (rst_n),
        .sample_clk_en (sample_clk_en),
        .chan_cfg      (chan_cfg),
        .op_req        (op_req)
    );

    opl_operator u_operator (
        .clk      (clk),
        .rst_n    (rst_n),
        .op_req   (op_req),
        .slot_out (slot_out)
    );

    opl_channel_mixer u_channel_mixer (
        .clk          (clk),
        .rst_n        (rst_n),
        .slot_out     (slot_out),
        .sample_l     (sample_l),
        .sample_r     (sample_r),
        .sample_valid (sample_valid)
    );

endmodule

// ==== tb_opl_synth.sv ====
// FM synth testbench
`timescale 1ns/1ps

module tb_opl_synth
    import opl_pkg::*;
();

    localparam int CLK_PERIOD    = 8;
    localparam int SAMPLE_BUDGET = 220;  // all tests together, rounded up
    localparam int TIMEOUT_NS    = SAMPLE_BUDGET * CLK_DIV_COUNT * CLK_PERIOD + 2000;

    logic                           clk;
    logic                           rst_n;
    logic                           wr;
    logic [REG_WIDTH-1:0]           addr;
    logic [REG_WIDTH-1:0]           data;
    logic signed [SAMPLE_WIDTH-1:0] sample_l;
    logic signed [SAMPLE_WIDTH-1:0] sample_r;
    logic                           sample_valid;

    logic [7:0]             sine_ref [32];           // reference quarter wave
    chan_cfg_t              shadow [NUM_CHANNELS];   // model of the register file
    logic [PHASE_WIDTH-1:0] m_phase [NUM_CHANNELS];  // model accumulators
    logic [31:0]            lfsr;
    bit                     discard;                 // skip first frame after a write
    int                     checks;
    int                     errors;
    int                     base_checks;
    int                     base_errors;

    opl_synth dut (
        .clk          (clk),
        .rst_n        (rst_n),
        .wr           (wr),
        .addr         (addr),
        .data         (data),
        .sample_l     (sample_l),
        .sample_r     (sample_r),
        .sample_valid (sample_valid)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // x^32 + x^22 + x^2 + x + 1, one step per bit taken
    function automatic logic [31:0] lfsr_bits(input int n);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int k = 0; k < n; k++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            r    = {r[30:0], fb};
        end
        return r;
    endfunction

    // full wave from the quarter table, quadrant in idx[6:5]
    function automatic int sine_value(input logic [6:0] idx);
        int i;
        int quad;
        int mag;
        i    = int'(idx[4:0]);
        quad = int'(idx[6:5]);
        if (quad == 1 || quad == 3) mag = int'(sine_ref[31 - i]);  // falling half
        else mag = int'(sine_ref[i]);
        if (quad >= 2) mag = -mag;  // negative half cycle
        return mag;
    endfunction

    function automatic int slot_value(input int c);
        if (!shadow[c].kon) return 0;
        return sine_value(m_phase[c][PHASE_WIDTH-1 -: 7]) >>> shadow[c].tl;
    endfunction

    function automatic logic [PHASE_WIDTH-1:0] phase_step(input int c);
        logic [63:0] full;
        full = (64'(shadow[c].fnum) << shadow[c].block) * 64'(shadow[c].mult);
        if (!shadow[c].kon) return '0;  // held at zero while keyed off
        return m_phase[c] + full[PHASE_WIDTH-1:0];  // wraps at 20 bits
    endfunction

    function automatic logic [7:0] key_block_byte(input int c, input logic kon);
        return {2'b00, kon, shadow[c].block, shadow[c].fnum[9:8]};
    endfunction

    task automatic check_value(input string what, input int exp, input int act);
        checks++;
        assert (act == exp) else begin
            $display("[ERROR] t=%0t %s: expected %0d, got %0d", $time, what, exp, act);
            errors++;
        end
    endtask

    // wait for one frame, predict it and step the model
    task automatic next_sample(output int exp_l, output int exp_r,
                               output int act_l, output int act_r);
        int v;
        do @(negedge clk); while (sample_valid !== 1'b1);
        act_l = int'(sample_l);
        act_r = int'(sample_r);
        exp_l = 0;
        exp_r = 0;
        for (int c = 0; c < NUM_CHANNELS; c++) begin
            v = slot_value(c);  // uses phase before update
            if (shadow[c].left_en) exp_l += v;
            if (shadow[c].right_en) exp_r += v;
        end
        for (int c = 0; c < NUM_CHANNELS; c++) m_phase[c] = phase_step(c);
    endtask

    // one write per frame, right after sample_valid
    task automatic write_reg(input logic [7:0] a, input logic [7:0] d);
        int el;
        int er;
        int al;
        int ar;
        int c;
        next_sample(el, er, al, ar);
        @(posedge clk);
        wr   <= 1'b1;
        addr <= a;
        data <= d;
        @(posedge clk);
        wr <= 1'b0;
        c = int'(a[1:0]);
        if (a[3:2] == 2'b00) begin
            case (a[7:4])
                4'h2: shadow[c].mult = d[3:0];
                4'h4: shadow[c].tl = d[3:0];
                4'hA: shadow[c].fnum[7:0] = d;
                4'hB: begin
                    shadow[c].kon       = d[5];
                    shadow[c].block     = d[4:2];
                    shadow[c].fnum[9:8] = d[1:0];
                end
                4'hC: begin
                    shadow[c].left_en  = d[4];
                    shadow[c].right_en = d[5];
                end
                default: ;  // unmapped group
            endcase
        end
        discard = 1'b1;
    endtask

    task automatic check_frames(input int n);
        int el;
        int er;
        int al;
        int ar;
        if (discard) begin
            next_sample(el, er, al, ar);  // dropped, model still steps
            discard = 1'b0;
        end
        for (int k = 0; k < n; k++) begin
            next_sample(el, er, al, ar);
            check_value("left", el, al);
            check_value("right", er, ar);
        end
    endtask

    task automatic report_test(input string name);
        $display("%-16s %0d checks, %0d errors", name, checks - base_checks,
                 errors - base_errors);
        base_checks = checks;
        base_errors = errors;
    endtask

    task automatic reset_silence();
        time t_prev;
        int  el;
        int  er;
        int  al;
        int  ar;
        t_prev = 0;
        for (int k = 0; k < 8; k++) begin
            next_sample(el, er, al, ar);
            check_value("left at reset", 0, al);
            check_value("right at reset", 0, ar);
            if (k > 0) check_value("sample period", CLK_DIV_COUNT * CLK_PERIOD,
                                   int'($time - t_prev));
            t_prev = $time;
        end
        report_test("reset_silence");
    endtask

    task automatic single_channel();
        write_reg(8'h40, 8'h00);  // tl 0
        write_reg(8'h20, 8'h03);  // mult 3
        write_reg(8'hC0, 8'h30);  // both sides
        write_reg(8'hA0, 8'hA5);
        write_reg(8'hB0, 8'h32);  // key on, block 4, fnum hi 2
        check_frames(16);
        report_test("single_channel");
    endtask

    task automatic routing();
        write_reg(8'hB0, key_block_byte(0, 1'b0));
        write_reg(8'h41, 8'h00);
        write_reg(8'h21, 8'h01);
        write_reg(8'hC1, 8'h10);  // left only
        write_reg(8'hA1, 8'h40);
        write_reg(8'hB1, 8'h35);  // key on, block 5
        check_frames(8);
        write_reg(8'hC1, 8'h20);  // right only
        check_frames(8);
        report_test("routing");
    endtask

    task automatic level_sweep();
        int tl_list [4] = '{0, 1, 4, 8};
        write_reg(8'hC1, 8'h30);
        for (int k = 0; k < 4; k++) begin
            write_reg(8'h41, 8'(tl_list[k]));
            check_frames(8);
        end
        report_test("level_sweep");
    endtask

    task automatic four_channel_mix();
        logic [9:0] fnum;
        logic [2:0] blk;
        logic [3:0] mult;
        logic [1:0] route;
        logic [7:0] c8;
        for (int c = 0; c < NUM_CHANNELS; c++) begin
            fnum  = 10'(lfsr_bits(10));
            blk   = 3'(lfsr_bits(3));
            mult  = 4'(lfsr_bits(4));
            route = 2'(lfsr_bits(2));  // bit 1 right, bit 0 left
            c8    = 8'(c);
            write_reg(8'h20 + c8, {4'h0, mult});
            write_reg(8'h40 + c8, 8'h00);
            write_reg(8'hA0 + c8, fnum[7:0]);
            write_reg(8'hC0 + c8, {2'b00, route, 4'h0});
            write_reg(8'hB0 + c8, {2'b00, 1'b1, blk, fnum[9:8]});
        end
        check_frames(32);
        report_test("four_channel_mix");
    endtask

    task automatic key_cycle();
        int el;
        int er;
        int al;
        int ar;
        write_reg(8'hC2, 8'h30);
        write_reg(8'h42, 8'h02);
        write_reg(8'hB2, key_block_byte(2, 1'b0));
        check_frames(8);  // others still sound, channel 2 silent
        for (int c = 0; c < NUM_CHANNELS; c++) begin
            if (c != 2) write_reg(8'hB0 + 8'(c), key_block_byte(c, 1'b0));
        end
        write_reg(8'hB2, key_block_byte(2, 1'b1));
        next_sample(el, er, al, ar);  // write landed between frames, already keyed
        check_value("restart left", int'(sine_ref[0]) >>> 2, al);
        check_value("restart right", int'(sine_ref[0]) >>> 2, ar);
        discard = 1'b0;
        check_frames(8);
        report_test("key_cycle");
    endtask

    initial begin
        #(TIMEOUT_NS);
        $display("watchdog expired: sample_valid stopped arriving");
        $display("Test failed");
        $finish;
    end

    initial begin
        rst_n   = 1'b0;
        wr      = 1'b0;
        addr    = '0;
        data    = '0;
        lfsr    = 32'hd452;
        discard = 1'b0;
        checks  = 0;
        errors  = 0;
        base_checks = 0;
        base_errors = 0;
        for (int c = 0; c < NUM_CHANNELS; c++) begin
            shadow[c]  = '0;
            m_phase[c] = '0;
        end
        $readmemh("sine_table.mem", sine_ref);
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        reset_silence();
        single_channel();
        routing();
        level_sweep();
        four_channel_mix();
        key_cycle();
        $display("total: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// ==== sine_table.mem ====
// quarter-wave sine, one 8-bit unsigned hex entry per line, index 0 to 31
06
13
1F
2C
38
44
50
5C
67
73
7E
88
93
9D
A7
B0
B9
C1
C9
D0
D7
DE
E4
E9
EE
F2
F6
F9
FB
FD
FE
FF

// ==== sources.f ====
opl_pkg.sv
opl_register_file.sv
opl_phase_generator.sv
opl_operator.sv
opl_channel_mixer.sv
opl_synth.sv
tb_opl_synth.sv

// ==== run_sim.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --assert -f sources.f --top-module tb_opl_synth -o sim_opl_synth
if [ $? -ne 0 ]; then
    echo "Verilator compile failed"
    exit 1
fi

output=$(./obj_dir/sim_opl_synth)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -q "Test passed"; then
    exit 0
fi
exit 1
